//--- project.f
design/predecode_pkg.sv
design/predecode_mem_fsm.sv
design/predecode_mult_fsm.sv
design/predecode_main.sv
testbench/predecode_properties.sv
testbench/predecode_tb.sv

//--- Bender.yml
package:
  name: predecode

sources:
  - design/predecode_pkg.sv
  - design/predecode_mem_fsm.sv
  - design/predecode_mult_fsm.sv
  - design/predecode_main.sv
  - target: test
    files:
      - testbench/predecode_properties.sv
      - testbench/predecode_tb.sv

//--- testbench/predecode_tb.sv
`default_nettype none

module predecode_tb import predecode_pkg::*; ();

        localparam int PC_WIDTH = 32;
        localparam int TIMEOUT  = 200;

        typedef struct packed {
                micro_op_t   uop;
                logic [31:0] pc;
                logic        taken;
        } expect_t;

        typedef expect_t expect_list_t[$];

        logic                i_clk, i_reset, i_valid, i_taken, i_irq, i_fiq;
        instr_word_u         i_instruction;
        logic [PC_WIDTH-1:0] i_pc;
        logic [31:0]         i_cpsr;
        logic                i_clear_from_writeback, i_data_stall;
        logic                i_clear_from_alu, i_stall_from_issue;
        micro_op_t           o_uop;
        logic                o_uop_valid, o_taken, o_stall_from_decode, o_clear_from_decode;
        logic [PC_WIDTH-1:0] o_pc, o_pc_from_decode;

        expect_t     expected_q[$];
        string       test_name;
        logic        flush_now;
        logic        hold_now;
        logic [31:0] pc_next;

        predecode_main #(.PC_WIDTH(PC_WIDTH)) predecode_main_i (.*);

        initial
        begin
                i_clk = 1'b0;
                forever
                begin
                        #2 i_clk = ~i_clk;
                end
        end

        task automatic stop_run();
                $display("Some tests failed");
                $fatal(1, "Stopped at the first error.");
        endtask

        task automatic report_error(input string what);
                $display("ERROR in %s: %s", test_name, what);
                stop_run();
        endtask

        task automatic check_value(input string what, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
                assert (act_val === exp_val)
                else
                begin
                        $display("FAIL %s %s: expected %h, actual %h",
                                 test_name, what, exp_val, act_val);
                        stop_run();
                end
        endtask

        // Expected micro-ops of one word, in output order.
        function automatic expect_list_t expand_ref(input logic [31:0] word,
                        input logic [31:0] pc, input logic taken_in, input logic irq,
                        input logic fiq, input logic [31:0] cpsr);
                expect_list_t list;
                expect_t      e;
                int           n;
                e           = '0;
                e.uop.kind  = UOP_PLAIN;
                e.uop.instr = word;
                e.uop.irq   = irq && !cpsr[CPSR_I_BIT];
                e.uop.fiq   = fiq && !cpsr[CPSR_F_BIT];
                e.pc        = pc;
                e.taken     = (word[27:25] == CLASS_BRANCH) &&
                              (taken_in || word[31:28] == COND_AL);
                n           = 0;
                if (word[27:25] == CLASS_BLOCK && word[15:0] != 16'd0)
                begin
                        for (int r = 0; r < 16; r++)
                        begin
                                if (word[r])
                                begin
                                        e.uop.kind = UOP_XFER;
                                        e.uop.rd   = 4'(r);
                                        e.uop.seq  = 4'(n);
                                        list.push_back(e);
                                        // Only seq 0 keeps interrupts.
                                        e.uop.irq  = 1'b0;
                                        e.uop.fiq  = 1'b0;
                                        n++;
                                end
                        end
                end
                else if (word[27:23] == 5'b00001 && word[7:4] == 4'b1001)
                begin
                        e.uop.kind = UOP_MUL_LO;
                        list.push_back(e);
                        e.uop.kind = UOP_MUL_HI;
                        e.uop.seq  = 4'd1;
                        e.uop.irq  = 1'b0;
                        e.uop.fiq  = 1'b0;
                        list.push_back(e);
                end
                else
                begin
                        list.push_back(e);
                end
                return list;
        endfunction

        // Kind 0 plain, 1 block, 2 long multiply, 3 branch.
        function automatic logic [31:0] random_word(input int kind);
                logic [31:0] w;
                w = $urandom;
                case (kind)
                        1: w[27:25] = CLASS_BLOCK;
                        2:
                        begin
                                w[27:23] = 5'b00001;
                                w[7:4]   = 4'b1001;
                        end
                        3:
                        begin
                                w[27:25] = CLASS_BRANCH;
                                if ($urandom % 2 == 0)
                                begin
                                        w[31:28] = COND_AL;
                                end
                        end
                        default:
                        begin
                                // Steer away from branch, block and long multiply.
                                if (w[27:26] == 2'b10)
                                begin
                                        w[27] = 1'b0;
                                end
                                if (w[27:23] == 5'b00001)
                                begin
                                        w[7] = 1'b0;
                                end
                        end
                endcase
                return w;
        endfunction

        task automatic drive_control(input int stall_pct, input int clear_pct);
                i_data_stall           = ($urandom % 100) < stall_pct;
                i_stall_from_issue     = ($urandom % 100) < stall_pct;
                i_clear_from_writeback = ($urandom % 100) < clear_pct;
                i_clear_from_alu       = ($urandom % 100) < clear_pct;
                // Writeback clear, data stall, ALU clear, issue stall.
                flush_now = i_clear_from_writeback || (i_clear_from_alu && !i_data_stall);
                hold_now  = !i_clear_from_writeback &&
                            (i_data_stall || (i_stall_from_issue && !i_clear_from_alu));
        endtask

        // Holds one word on the inputs until it is accepted or flushed.
        task automatic present_word(input logic [31:0] word, input logic taken_in,
                        input logic irq, input logic fiq, input logic [31:0] cpsr,
                        input int stall_pct, input int clear_pct);
                expect_list_t exp_list;
                logic         predicted;
                logic         redirect;
                logic [31:0]  target;
                logic         stall_seen;
                logic         done;
                int           cycles;
                exp_list = expand_ref(word, pc_next, taken_in, irq, fiq, cpsr);
                foreach (exp_list[k])
                begin
                        expected_q.push_back(exp_list[k]);
                end
                predicted     = exp_list[0].taken;
                target        = pc_next + 32'd8 + {{6{word[23]}}, word[23:0], 2'b00};
                i_instruction = word;
                i_pc          = pc_next;
                i_taken       = taken_in;
                i_irq         = irq;
                i_fiq         = fiq;
                i_cpsr        = cpsr;
                i_valid       = 1'b1;
                done          = 1'b0;
                cycles        = 0;
                while (!done)
                begin
                        drive_control(stall_pct, clear_pct);
                        #1;
                        stall_seen = o_stall_from_decode;
                        redirect   = predicted && !hold_now && !flush_now;
                        // Stall while more than one micro-op is still to be loaded.
                        check_value("stall", expected_q.size() > 1, stall_seen);
                        check_value("clear_from_decode", redirect, o_clear_from_decode);
                        check_value("pc_from_decode", redirect ? target : 32'd0, o_pc_from_decode);
                        @(negedge i_clk);
                        cycles++;
                        if (flush_now)
                        begin
                                expected_q.delete();
                                done = 1'b1;
                        end
                        else if (!stall_seen && !hold_now)
                        begin
                                done = 1'b1;
                        end
                        else if (cycles > TIMEOUT)
                        begin
                                report_error("instruction word not accepted in time");
                        end
                end
                pc_next = pc_next + 32'd4;
        endtask

        task automatic drain_scoreboard();
                int cycles;
                i_valid = 1'b0;
                drive_control(0, 0);
                cycles = 0;
                while (expected_q.size() != 0)
                begin
                        @(negedge i_clk);
                        cycles++;
                        if (cycles > TIMEOUT)
                        begin
                                report_error("expected micro-ops never appeared");
                        end
                end
        endtask

        task automatic run_words(input string name, input int count, input int kind,
                        input int stall_pct, input int clear_pct, input logic irq_on);
                logic [31:0] bits;
                int          k;
                test_name = name;
                for (int i = 0; i < count; i++)
                begin
                        k    = (kind < 0) ? int'($urandom % 4) : kind;
                        bits = $urandom;
                        present_word(random_word(k), bits[0], irq_on && bits[1],
                                     irq_on && bits[2], irq_on ? $urandom : 32'd0,
                                     stall_pct, clear_pct);
                end
                drain_scoreboard();
        endtask

        // Pops one expected entry per freshly loaded output.
        initial
        begin : compare_outputs
                expect_t e;
                forever
                begin
                        @(posedge i_clk);
                        #1;
                        if (!i_reset && o_uop_valid && !hold_now)
                        begin
                                if (expected_q.size() == 0)
                                begin
                                        report_error("micro-op on the output with none expected");
                                end
                                else
                                begin
                                        e = expected_q.pop_front();
                                        check_value("uop", e.uop, o_uop);
                                        check_value("pc", e.pc, o_pc);
                                        check_value("taken", e.taken, o_taken);
                                end
                        end
                end
        end

        initial
        begin
                void'($urandom(73));
                i_reset       = 1'b1;
                i_valid       = 1'b0;
                i_instruction = '0;
                i_pc          = '0;
                i_taken       = 1'b0;
                i_irq         = 1'b0;
                i_fiq         = 1'b0;
                i_cpsr        = '0;
                drive_control(0, 0);
                pc_next       = 32'h0000_1000;
                repeat (8) @(negedge i_clk);
                test_name = "reset";
                check_value("uop_valid", 0, o_uop_valid);
                check_value("taken", 0, o_taken);
                check_value("stall", 0, o_stall_from_decode);
                check_value("pc", 0, o_pc);
                i_reset = 1'b0;
                run_words("plain", 20, 0, 0, 0, 1'b0);
                run_words("block", 10, 1, 0, 0, 1'b0);
                present_word({COND_AL, CLASS_BLOCK, 9'h0, 16'h0000}, 1'b0, 1'b1, 1'b1, 0, 0, 0);
                present_word({COND_AL, CLASS_BLOCK, 9'h0, 16'hFFFF}, 1'b0, 1'b1, 1'b1, 0, 0, 0);
                drain_scoreboard();
                run_words("long_mul", 8, 2, 0, 0, 1'b1);
                run_words("branch", 24, 3, 0, 0, 1'b0);
                run_words("interrupts", 20, -1, 0, 0, 1'b1);
                run_words("stall_flush", 80, -1, 30, 8, 1'b1);
                run_words("after_flush", 6, -1, 0, 0, 1'b1);
                if (expected_q.size() == 0)
                begin
                        $display("All tests passed");
                        $finish;
                end
                else
                begin
                        report_error("scoreboard not empty at the end");
                end
        end

endmodule

`default_nettype wire

//--- testbench/predecode_properties.sv
`default_nettype none

module predecode_properties import predecode_pkg::*;
#(
        parameter int PC_WIDTH = 32
)
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_clear_from_writeback,
        input  logic                i_data_stall,
        input  logic                i_clear_from_alu,
        input  logic                i_stall_from_issue,
        input  micro_op_t           i_uop,
        input  logic                i_uop_valid,
        input  logic [PC_WIDTH-1:0] i_pc,
        input  logic                i_taken,
        input  logic                i_clear_from_decode
);

        logic flush_req;
        logic hold_req;

        // Writeback clear, data stall, ALU clear, issue stall.
        assign flush_req = i_clear_from_writeback || (i_clear_from_alu && !i_data_stall);
        assign hold_req  = !i_clear_from_writeback &&
                           (i_data_stall || (i_stall_from_issue && !i_clear_from_alu));

        // A flush empties the output register.
        flush_clears_valid: assert property (@(posedge i_clk) disable iff (i_reset)
                flush_req |=> !i_uop_valid)
        else $error("output valid in the cycle after a flush");

        // Output register frozen under hold.
        hold_keeps_output: assert property (@(posedge i_clk) disable iff (i_reset)
                hold_req |=> ($stable(i_uop) && $stable(i_uop_valid) &&
                              $stable(i_pc) && $stable(i_taken)))
        else $error("output register changed under hold");

        // No fetch redirect while any stall is raised.
        no_redirect_in_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                !((i_data_stall || i_stall_from_issue) && i_clear_from_decode))
        else $error("fetch redirect raised during a hold");

endmodule

bind predecode_main predecode_properties #(.PC_WIDTH(PC_WIDTH)) u_properties (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_uop                  (o_uop),
        .i_uop_valid            (o_uop_valid),
        .i_pc                   (o_pc),
        .i_taken                (o_taken),
        .i_clear_from_decode    (o_clear_from_decode)
);

`default_nettype wire

//--- design/predecode_main.sv
`default_nettype none

module predecode_main import predecode_pkg::*;
#(
        parameter int PC_WIDTH = 32
)
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Fetched instruction.
        input  instr_word_u         i_instruction,
        input  logic                i_valid,
        input  logic [PC_WIDTH-1:0] i_pc,

        // Static prediction hint from fetch.
        input  logic                i_taken,

        input  logic                i_irq,
        input  logic                i_fiq,
        input  logic [31:0]         i_cpsr,

        // Clears and stalls, highest priority first.
        input  logic                i_clear_from_writeback,
        input  logic                i_data_stall,
        input  logic                i_clear_from_alu,
        input  logic                i_stall_from_issue,

        output micro_op_t           o_uop,
        output logic                o_uop_valid,
        output logic [PC_WIDTH-1:0] o_pc,
        output logic                o_taken,

        output logic                o_stall_from_decode,

        // Fetch redirect on a predicted-taken branch.
        output logic                o_clear_from_decode,
        output logic [PC_WIDTH-1:0] o_pc_from_decode
);

        logic                flush;
        logic                hold;

        micro_op_t           entry_uop;
        micro_op_t           mem_uop;
        logic                mem_valid;
        logic                mem_busy;
        micro_op_t           mult_uop;
        logic                mult_valid;
        logic                mult_busy;

        logic                taken_nxt;
        logic [PC_WIDTH-1:0] branch_offset;

        // A data stall shields the pipeline from an ALU clear.
        assign flush = i_clear_from_writeback || (!i_data_stall && i_clear_from_alu);
        assign hold  = !flush && (i_data_stall || i_stall_from_issue);

        always_comb
        begin
                entry_uop       = '0;
                entry_uop.kind  = UOP_PLAIN;
                entry_uop.instr = i_instruction;
                entry_uop.irq   = i_irq;
                entry_uop.fiq   = i_fiq;
        end

        // The multiply split holds the block expander.
        predecode_mem_fsm u_mem_fsm (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flush (flush),
                .i_hold  (hold || mult_busy),
                .i_uop   (entry_uop),
                .i_valid (i_valid),
                .o_uop   (mem_uop),
                .o_valid (mem_valid),
                .o_busy  (mem_busy)
        );

        predecode_mult_fsm u_mult_fsm (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flush (flush),
                .i_hold  (hold),
                .i_uop   (mem_uop),
                .i_valid (mem_valid),
                .o_uop   (mult_uop),
                .o_valid (mult_valid),
                .o_busy  (mult_busy)
        );

        assign o_stall_from_decode = mem_busy || mult_busy;

        // Static prediction on the micro-op about to be registered.
        always_comb
        begin
                branch_offset       = PC_WIDTH'($signed(mult_uop.instr.br.offset)) << 2;
                taken_nxt           = 1'b0;
                o_clear_from_decode = 1'b0;
                o_pc_from_decode    = '0;
                if (mult_valid && (mult_uop.instr.br.op_class == CLASS_BRANCH))
                begin
                        taken_nxt = i_taken || (mult_uop.instr.br.cond == COND_AL);
                end
                if (taken_nxt && !hold && !flush)
                begin
                        o_clear_from_decode = 1'b1;
                        // PC reads two words ahead.
                        o_pc_from_decode    = i_pc + PC_WIDTH'(8) + branch_offset;
                end
        end

        // Output register.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || flush)
                begin
                        o_uop       <= '0;
                        o_uop_valid <= 1'b0;
                        o_pc        <= '0;
                        o_taken     <= 1'b0;
                end
                else if (!hold)
                begin
                        o_uop       <= mult_uop;
                        o_uop.irq   <= mult_uop.irq && !i_cpsr[CPSR_I_BIT];
                        o_uop.fiq   <= mult_uop.fiq && !i_cpsr[CPSR_F_BIT];
                        o_uop_valid <= mult_valid;
                        o_pc        <= i_pc;
                        o_taken     <= taken_nxt;
                end
        end

endmodule

`default_nettype wire

//--- design/predecode_mult_fsm.sv
`default_nettype none

module predecode_mult_fsm import predecode_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,

        input  logic      i_flush,
        input  logic      i_hold,

        input  micro_op_t i_uop,
        input  logic      i_valid,

        output micro_op_t o_uop,
        output logic      o_valid,

        // High while the low half is presented.
        output logic      o_busy
);

        // 0 for the low half, 1 for the high half.
        logic phase_q;
        logic is_mul;

        assign is_mul  = i_valid && is_long_mul(i_uop.instr);
        assign o_busy  = is_mul && !phase_q;
        assign o_valid = i_valid;

        always_comb
        begin
                o_uop = i_uop;
                if (is_mul)
                begin
                        if (!phase_q)
                        begin
                                o_uop.kind = UOP_MUL_LO;
                                o_uop.seq  = 4'd0;
                        end
                        else
                        begin
                                o_uop.kind = UOP_MUL_HI;
                                o_uop.seq  = 4'd1;
                                // Interrupts stay with the low half.
                                o_uop.irq  = 1'b0;
                                o_uop.fiq  = 1'b0;
                        end
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        phase_q <= 1'b0;
                end
                else if (!i_hold)
                begin
                        phase_q <= o_busy;
                end
        end

endmodule

`default_nettype wire

//--- design/predecode_mem_fsm.sv
`default_nettype none

module predecode_mem_fsm import predecode_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,

        // Resolved flush and hold from the top level.
        input  logic      i_flush,
        input  logic      i_hold,

        input  micro_op_t i_uop,
        input  logic      i_valid,

        output micro_op_t o_uop,
        output logic      o_valid,

        // High while more transfers remain after this one.
        output logic      o_busy
);

        logic        active_q;
        logic [3:0]  seq_q;
        logic [15:0] mask_q;

        logic        is_block;
        logic [15:0] cur_list;
        logic [15:0] rest_list;
        logic [3:0]  low_idx;

        // An empty list is not expanded.
        assign is_block = i_valid &&
                          (i_uop.instr.blk.op_class == CLASS_BLOCK) &&
                          (i_uop.instr.blk.reg_list != 16'd0);

        // Remaining registers and the lowest one still to go.
        always_comb
        begin
                cur_list = active_q ? mask_q : i_uop.instr.blk.reg_list;
                low_idx  = 4'd0;
                for (int i = 15; i >= 0; i--)
                begin
                        if (cur_list[i])
                        begin
                                low_idx = 4'(i);
                        end
                end
                // Clear the lowest set bit.
                rest_list = cur_list & (cur_list - 16'd1);
        end

        assign o_busy  = is_block && (rest_list != 16'd0);
        assign o_valid = i_valid;

        always_comb
        begin
                o_uop = i_uop;
                if (is_block)
                begin
                        o_uop.kind = UOP_XFER;
                        o_uop.rd   = low_idx;
                        o_uop.seq  = seq_q;
                        // Interrupts ride on the first transfer only.
                        if (seq_q != 4'd0)
                        begin
                                o_uop.irq = 1'b0;
                                o_uop.fiq = 1'b0;
                        end
                end
        end

        // Expansion control.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        active_q <= 1'b0;
                        seq_q    <= 4'd0;
                end
                else if (!i_hold)
                begin
                        if (o_busy)
                        begin
                                active_q <= 1'b1;
                                seq_q    <= seq_q + 4'd1;
                        end
                        else
                        begin
                                active_q <= 1'b0;
                                seq_q    <= 4'd0;
                        end
                end
        end

        // Register list still to be emitted.
        always_ff @(posedge i_clk)
        begin
                if (!i_hold && o_busy)
                begin
                        mask_q <= rest_list;
                end
        end

endmodule

`default_nettype wire

//--- design/predecode_pkg.sv
`default_nettype none

package predecode_pkg;

        // Condition code for an unconditional instruction.
        localparam logic [3:0] COND_AL = 4'hE;

        // Major instruction classes from bits 27 to 25.
        localparam logic [2:0] CLASS_BRANCH = 3'b101;
        localparam logic [2:0] CLASS_BLOCK  = 3'b100;

        // Interrupt mask positions in the CPSR.
        localparam int CPSR_I_BIT = 7;
        localparam int CPSR_F_BIT = 6;

        // Branch view of an instruction word.
        typedef struct packed {
                logic [3:0]         cond;
                logic [2:0]         op_class;
                logic               link;
                logic signed [23:0] offset;
        } branch_fmt_t;

        // Load/store-multiple view of the same word.
        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  op_class;
                logic        pre;
                logic        up;
                logic        psr;
                logic        wback;
                logic        load;
                logic [3:0]  rn;
                logic [15:0] reg_list;
        } blk_xfer_fmt_t;

        // One word, two decodings.
        typedef union packed {
                branch_fmt_t   br;
                blk_xfer_fmt_t blk;
        } instr_word_u;

        typedef enum logic [1:0] {
                UOP_PLAIN,
                UOP_XFER,
                UOP_MUL_LO,
                UOP_MUL_HI
        } uop_kind_e;

        // Element passed along the expander chain.
        typedef struct packed {
                uop_kind_e   kind;
                instr_word_u instr;
                logic [3:0]  rd;
                logic [3:0]  seq;
                logic        irq;
                logic        fiq;
        } micro_op_t;

        // UMULL/UMLAL/SMULL/SMLAL encoding.
        function automatic logic is_long_mul(input logic [31:0] word);
                return (word[27:23] == 5'b00001) && (word[7:4] == 4'b1001);
        endfunction

endpackage

`default_nettype wire
